//--- verification/rob_patterns.txt
# Fields in hex: alloc rd itype pc miss, allocn n rd itype pcbase, cpl k value exc,
# bypass rs1 rs2 hit1 val1 hit2 val2, axw addr data, axr addr expected, axrm addr
test in_order
allocn a 3 0 1000
cplall
drain
axrm 24
end
test backpressure
stall 1
allocn a 5 0 2000
ready 0
cplall
idle 8
stall 0
drain
axw 20 1
allocn 3 5 0 3000
cplall
idle 8
axr 20 1
axw 20 0
drain
end
test bypass
stall 1
alloc 7 0 4000 0
alloc 7 0 4004 0
alloc 7 0 4008 0
alloc 0 0 400c 0
alloc 9 0 4010 0
cpl 0 11 0
cpl 1 22 0
cpl 3 44 0
bypass 7 0 1 22 0 0
bypass 9 7 0 0 1 22
bypass 0 3 0 0 0 0
cplall
stall 0
drain
end
test exception
stall 1
alloc 3 2 5000 abcd0040
alloc 4 0 5004 0
alloc 5 0 5008 0
cpl 1 66 0
cpl 2 77 0
cpl 0 0 3
stall 0
nuke
idle 6
axr 0 5000
axr 4 abcd0040
end
test priv
alloc 5 4 6000 0
alloc 4 4 6004 0
alloc 0 5 6008 0
cpl 0 cafe0005 0
cpl 1 beef0004 0
cpl 2 0 0
drain
axr 14 cafe0005
axr 10 0
axrm 24
end

//--- vlog.f
common/rob_pkg.sv
reorder_buffer/reorder_buffer.sv
reorder_buffer/rob_bypass.sv
source/priv_regs.sv
source/rob_subsystem.sv
verification/tb_rob_subsystem.sv

//--- Bender.yml
package:
  name: rob_subsystem

sources:
  - common/rob_pkg.sv
  - reorder_buffer/reorder_buffer.sv
  - reorder_buffer/rob_bypass.sv
  - source/priv_regs.sv
  - source/rob_subsystem.sv
  - target: simulation
    files:
      - verification/tb_rob_subsystem.sv

//--- verification/tb_rob_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rob_subsystem;

    localparam int ROB_SIZE = 10;
    localparam int CYCLES_PER_LINE = 200;
    localparam int WAIT_LIMIT = 100;

    // One in-flight instruction as the model sees it
    typedef struct {
        logic [3:0]  idx;
        logic [31:0] pc;
        logic [31:0] miss;
        logic [31:0] value;
        logic [4:0]  rd;
        logic [2:0]  itype;
        logic [2:0]  exc;
        bit          done;
    } entry_t;

    logic                clk;
    logic                reset;
    logic                alloc_valid;
    rob_pkg::alloc_req_t alloc_req;
    logic                alloc_ready;
    logic [3:0]          alloc_idx;
    rob_pkg::complete_t  alu_cpl;
    rob_pkg::complete_t  mem_cpl;
    rob_pkg::complete_t  mul_cpl;
    logic                stall;
    rob_pkg::retire_t    retire;
    logic                rob_nuke;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic                rs1_hit;
    logic [31:0]         rs1_value;
    logic                rs2_hit;
    logic [31:0]         rs2_value;
    rob_pkg::axil_req_t  axil_req;
    rob_pkg::axil_rsp_t  axil_rsp;

    entry_t      model_q[$];
    logic [3:0]  test_idx[$];
    logic [31:0] rm_model[8];
    logic [31:0] retired_model;
    logic        hold_model;
    logic [3:0]  exp_tail;
    logic        nuke_exp;
    logic [31:0] lcg_state;
    int          n_retired;
    int          checks;
    int          errors;
    int          n_lines;

    rob_subsystem #(
        .ROB_SIZE(ROB_SIZE)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .alloc_valid(alloc_valid),
        .alloc_req(alloc_req),
        .alloc_ready(alloc_ready),
        .alloc_idx(alloc_idx),
        .alu_cpl(alu_cpl),
        .mem_cpl(mem_cpl),
        .mul_cpl(mul_cpl),
        .stall(stall),
        .retire(retire),
        .rob_nuke(rob_nuke),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_hit(rs1_hit),
        .rs1_value(rs1_value),
        .rs2_hit(rs2_hit),
        .rs2_value(rs2_value),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            $display("FAIL %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("ERROR: %s", msg);
            errors++;
        end
    endtask

    task automatic alloc_one(input logic [4:0] rd, input logic [2:0] itype,
                             input logic [31:0] pc, input logic [31:0] miss);
        entry_t e;
        int     n;
        n = 0;
        @(negedge clk);
        while (!alloc_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        check_true(alloc_ready, "alloc_ready never rose for an allocation");
        check_hex("alloc_idx", exp_tail, alloc_idx);
        @(posedge clk);
        alloc_valid     <= 1'b1;
        alloc_req.pc    <= pc;
        alloc_req.miss_addr <= miss;
        alloc_req.rd    <= rd;
        alloc_req.itype <= rob_pkg::instr_type_e'(itype);
        @(posedge clk);
        alloc_valid <= 1'b0;
        e = '{idx: exp_tail, pc: pc, miss: miss, value: 0, rd: rd, itype: itype,
              exc: 0, done: 0};
        model_q.push_back(e);
        test_idx.push_back(exp_tail);
        exp_tail = (exp_tail == 4'(ROB_SIZE - 1)) ? 4'd0 : exp_tail + 4'd1;
    endtask

    task automatic drive_cpl(input int port, input logic [3:0] idx,
                             input logic [31:0] value, input logic [2:0] exc);
        rob_pkg::complete_t c;
        bit                 found;
        c.valid = 1'b1;
        c.idx   = idx;
        c.value = value;
        c.exc   = rob_pkg::exc_code_e'(exc);
        found   = 0;
        @(posedge clk);
        case (port)
            0: alu_cpl <= c;
            1: mem_cpl <= c;
            default: mul_cpl <= c;
        endcase
        @(posedge clk);
        alu_cpl.valid <= 1'b0;
        mem_cpl.valid <= 1'b0;
        mul_cpl.valid <= 1'b0;
        foreach (model_q[i]) begin
            if (model_q[i].idx == idx) begin
                model_q[i].value = value;
                model_q[i].exc   = exc;
                model_q[i].done  = 1;
                found = 1;
            end
        end
        check_true(found, "completion named an entry that is not in flight");
    endtask

    // Completes every unfinished entry in a shuffled order
    task automatic complete_shuffled();
        logic [3:0] order[$];
        logic [3:0] t;
        int         j;
        foreach (model_q[i]) begin
            if (!model_q[i].done) order.push_back(model_q[i].idx);
        end
        for (int i = order.size() - 1; i > 0; i--) begin
            j = lcg_next() % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        foreach (order[i]) begin
            drive_cpl(lcg_next() % 3, order[i], lcg_next(), 3'd0);
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        axil_req.bready  <= 1'b1;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge clk);
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        check_hex("bresp", 32'd0, axil_rsp.bresp);
        @(posedge clk);
        axil_req.bready <= 1'b0;
        if (addr <= 8'h1c) rm_model[addr[4:2]] = data;
        if (addr == 8'h20) hold_model = data[0];
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        check_hex("rresp", 32'd0, axil_rsp.rresp);
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    function automatic logic [31:0] model_reg(input logic [7:0] addr);
        if (addr <= 8'h1c) return rm_model[addr[4:2]];
        if (addr == 8'h20) return {31'd0, hold_model};
        if (addr == 8'h24) return retired_model;
        return 32'd0;
    endfunction

    // Compares each retirement with the oldest model entry
    always @(negedge clk) begin
        entry_t e;
        if (!reset) begin
            if (nuke_exp || rob_nuke) check_hex("rob_nuke", nuke_exp, rob_nuke);
            nuke_exp = 0;
            if (retire.valid) begin
                if (model_q.size() == 0) begin
                    check_true(0, "an entry retired with nothing in flight");
                end else begin
                    e = model_q.pop_front();
                    check_true(e.done, "an unfinished entry retired");
                    check_hex("retire.idx", e.idx, retire.idx);
                    check_hex("retire.pc", e.pc, retire.pc);
                    check_hex("retire.miss_addr", e.miss, retire.miss_addr);
                    check_hex("retire.value", e.value, retire.value);
                    check_hex("retire.rd", e.rd, retire.rd);
                    check_hex("retire.itype", e.itype, retire.itype);
                    check_hex("retire.exc", e.exc, retire.exc);
                    n_retired++;
                    if (e.exc != 0) begin
                        rm_model[0] = e.pc;
                        rm_model[1] = e.miss;
                        model_q.delete();
                        exp_tail = 0;
                        nuke_exp = 1;
                    end else begin
                        retired_model++;
                        if (e.itype == 3'd4) rm_model[e.rd[2:0]] = e.value;
                        if (e.itype == 3'd5) rm_model[4] = 32'd0;
                    end
                end
            end
        end
    end

    initial begin
        wait (n_lines > 0);
        repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish",
                 n_lines * CYCLES_PER_LINE);
        $display("Test failed");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        int          c0;
        int          e0;
        string       line;
        string       cmd;
        string       tname;
        logic [31:0] a[6];
        logic [31:0] rdata;
        clk = 0;
        reset = 1;
        alloc_valid = 0;
        alloc_req = '0;
        alu_cpl = '0;
        mem_cpl = '0;
        mul_cpl = '0;
        stall = 0;
        rs1 = 0;
        rs2 = 0;
        axil_req = '0;
        lcg_state = 32'hfa090de3;
        foreach (rm_model[i]) rm_model[i] = 0;
        retired_model = 0;
        hold_model = 0;
        exp_tail = 0;
        nuke_exp = 0;
        n_retired = 0;
        checks = 0;
        errors = 0;
        c0 = 0;
        e0 = 0;
        tname = "";
        fd = $fopen("verification/rob_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
            errors++;
        end else begin
            n = 0;
            while ($fgets(line, fd)) n++;
            $fclose(fd);
            n_lines = n;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        fd = $fopen("verification/rob_patterns.txt", "r");
        while (fd != 0 && $fgets(line, fd)) begin
            cmd = "";
            foreach (a[i]) a[i] = 0;
            void'($sscanf(line, "%s %h %h %h %h %h %h", cmd, a[0], a[1], a[2], a[3], a[4], a[5]));
            if (cmd == "test") begin
                void'($sscanf(line, "%s %s", cmd, tname));
                c0 = checks;
                e0 = errors;
                test_idx.delete();
            end else if (cmd == "end") begin
                $display("test %s: %0d checks, %0d errors", tname, checks - c0, errors - e0);
            end else if (cmd == "alloc") begin
                alloc_one(a[0][4:0], a[1][2:0], a[2], a[3]);
            end else if (cmd == "allocn") begin
                for (int i = 0; i < a[0]; i++) begin
                    alloc_one(a[1][4:0], a[2][2:0], a[3] + 4 * i, 32'd0);
                end
            end else if (cmd == "cpl") begin
                drive_cpl(a[0] % 3, test_idx[a[0]], a[1], a[2][2:0]);
            end else if (cmd == "cplall") begin
                complete_shuffled();
            end else if (cmd == "drain") begin
                n = 0;
                while (model_q.size() != 0 && n < WAIT_LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                check_true(model_q.size() == 0, "entries were left unretired");
            end else if (cmd == "stall") begin
                @(posedge clk);
                stall <= a[0][0];
            end else if (cmd == "idle") begin
                n = n_retired;
                repeat (a[0]) @(negedge clk);
                check_true(n == n_retired, "an entry retired while retirement was frozen");
            end else if (cmd == "ready") begin
                @(negedge clk);
                check_hex("alloc_ready", a[0], alloc_ready);
            end else if (cmd == "bypass") begin
                @(posedge clk);
                rs1 <= a[0][4:0];
                rs2 <= a[1][4:0];
                @(negedge clk);
                check_hex("rs1_hit", a[2], rs1_hit);
                if (a[2][0]) check_hex("rs1_value", a[3], rs1_value);
                check_hex("rs2_hit", a[4], rs2_hit);
                if (a[4][0]) check_hex("rs2_value", a[5], rs2_value);
            end else if (cmd == "axw") begin
                axil_write(a[0][7:0], a[1]);
            end else if (cmd == "axr") begin
                axil_read(a[0][7:0], rdata);
                check_hex($sformatf("rdata@%h", a[0][7:0]), a[1], rdata);
            end else if (cmd == "axrm") begin
                axil_read(a[0][7:0], rdata);
                check_hex($sformatf("rdata@%h", a[0][7:0]), model_reg(a[0][7:0]), rdata);
            end else if (cmd == "nuke") begin
                n = 0;
                @(negedge clk);
                while (!rob_nuke && n < WAIT_LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                check_true(rob_nuke, "rob_nuke never rose after the exception");
                @(negedge clk);
                check_hex("alloc_idx", 32'd0, alloc_idx);
                check_true(model_q.size() == 0, "entries survived the flush");
            end
        end
        if (fd != 0) $fclose(fd);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/rob_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module rob_subsystem #(
    parameter int ROB_SIZE = 10
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alloc_valid,
    input  rob_pkg::alloc_req_t           alloc_req,
    output logic                          alloc_ready,
    output logic [rob_pkg::ROB_IDX_W-1:0] alloc_idx,
    input  rob_pkg::complete_t            alu_cpl,
    input  rob_pkg::complete_t            mem_cpl,
    input  rob_pkg::complete_t            mul_cpl,
    input  logic                          stall,
    output rob_pkg::retire_t              retire,
    output logic                          rob_nuke,
    input  logic [4:0]                    rs1,
    input  logic [4:0]                    rs2,
    output logic                          rs1_hit,
    output logic [31:0]                   rs1_value,
    output logic                          rs2_hit,
    output logic [31:0]                   rs2_value,
    input  rob_pkg::axil_req_t            axil_req,
    output rob_pkg::axil_rsp_t            axil_rsp
);

    logic [ROB_SIZE-1:0]                 ent_valid;
    logic [ROB_SIZE-1:0]                 ent_done;
    logic [ROB_SIZE-1:0][4:0]            ent_rd;
    logic [ROB_SIZE-1:0][31:0]           ent_value;
    logic [rob_pkg::ROB_IDX_W-1:0]       head;
    logic [rob_pkg::ROB_IDX_W-1:0]       tail;
    logic                                retire_hold;

    reorder_buffer #(
        .ROB_SIZE(ROB_SIZE)
    ) rob0 (
        .clk(clk),
        .reset(reset),
        .alloc_valid(alloc_valid),
        .alloc_req(alloc_req),
        .alloc_ready(alloc_ready),
        .alloc_idx(alloc_idx),
        .alu_cpl(alu_cpl),
        .mem_cpl(mem_cpl),
        .mul_cpl(mul_cpl),
        .stall(stall),
        .retire_hold(retire_hold),
        .retire(retire),
        .rob_nuke(rob_nuke),
        .ent_valid(ent_valid),
        .ent_done(ent_done),
        .ent_rd(ent_rd),
        .ent_value(ent_value),
        .head(head),
        .tail(tail)
    );

    rob_bypass #(
        .ROB_SIZE(ROB_SIZE)
    ) bypass0 (
        .ent_valid(ent_valid),
        .ent_done(ent_done),
        .ent_rd(ent_rd),
        .ent_value(ent_value),
        .head(head),
        .tail(tail),
        .rs1(rs1),
        .rs2(rs2),
        .rs1_hit(rs1_hit),
        .rs1_value(rs1_value),
        .rs2_hit(rs2_hit),
        .rs2_value(rs2_value)
    );

    priv_regs priv0 (
        .clk(clk),
        .reset(reset),
        .retire(retire),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .retire_hold(retire_hold)
    );

endmodule

`default_nettype wire

//--- source/priv_regs.sv
`timescale 1ns/1ps
`default_nettype none

module priv_regs (
    input  logic               clk,
    input  logic               reset,
    input  rob_pkg::retire_t   retire,
    input  rob_pkg::axil_req_t axil_req,
    output rob_pkg::axil_rsp_t axil_rsp,
    output logic               retire_hold
);

    // Architectural state
    logic [7:0][31:0] rm_q;
    logic             hold_q;
    logic [31:0]      retired_q;

    // Bus state
    logic        aw_got_q;
    logic        w_got_q;
    logic        bvalid_q;
    logic        rvalid_q;
    logic [7:0]  awaddr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;
    logic [31:0] rdata_q;

    logic        aw_hs;
    logic        w_hs;
    logic        ar_hs;
    logic        wr_en;
    logic [7:0]  wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic [31:0] rd_word;

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign aw_hs = axil_req.awvalid && !aw_got_q && !bvalid_q;
    assign w_hs  = axil_req.wvalid && !w_got_q && !bvalid_q;
    assign ar_hs = axil_req.arvalid && !rvalid_q;

    // Address and data may arrive in either order
    assign wr_en   = (aw_got_q || aw_hs) && (w_got_q || w_hs);
    assign wr_addr = aw_got_q ? awaddr_q : axil_req.awaddr;
    assign wr_data = w_got_q ? wdata_q : axil_req.wdata;
    assign wr_strb = w_got_q ? wstrb_q : axil_req.wstrb;

    always_comb begin
        rd_word = '0;
        if (axil_req.araddr <= rob_pkg::RM_LAST_OFS) begin
            rd_word = rm_q[axil_req.araddr[4:2]];
        end else if (axil_req.araddr == rob_pkg::CTRL_OFS) begin
            rd_word = {31'd0, hold_q};
        end else if (axil_req.araddr == rob_pkg::RETIRED_OFS) begin
            rd_word = retired_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_got_q <= 1'b0;
            w_got_q  <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (wr_en) begin
                aw_got_q <= 1'b0;
                w_got_q  <= 1'b0;
                bvalid_q <= 1'b1;
            end else begin
                if (aw_hs) aw_got_q <= 1'b1;
                if (w_hs)  w_got_q  <= 1'b1;
            end
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) awaddr_q <= axil_req.awaddr;
        if (w_hs) begin
            wdata_q <= axil_req.wdata;
            wstrb_q <= axil_req.wstrb;
        end
        if (ar_hs) rdata_q <= rd_word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rm_q      <= '0;
            hold_q    <= 1'b0;
            retired_q <= '0;
        end else begin
            if (wr_en) begin
                if (wr_addr <= rob_pkg::RM_LAST_OFS) begin
                    rm_q[wr_addr[4:2]] <= merge(rm_q[wr_addr[4:2]], wr_data, wr_strb);
                end else if (wr_addr == rob_pkg::CTRL_OFS && wr_strb[0]) begin
                    hold_q <= wr_data[0];
                end
            end
            // Retirement overrides a bus write to the same register
            if (retire.valid) begin
                if (retire.exc != rob_pkg::EXC_NONE) begin
                    rm_q[0] <= retire.pc;
                    rm_q[1] <= retire.miss_addr;
                end else begin
                    retired_q <= retired_q + 32'd1;
                    case (retire.itype)
                        rob_pkg::ITYPE_MOVRM: rm_q[retire.rd[2:0]] <= retire.value;
                        rob_pkg::ITYPE_IRET:  rm_q[4] <= '0;
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        axil_rsp.awready = !aw_got_q && !bvalid_q;
        axil_rsp.wready  = !w_got_q && !bvalid_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = rob_pkg::AXIL_OKAY;
        axil_rsp.arready = !rvalid_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rob_pkg::AXIL_OKAY;
    end

    assign retire_hold = hold_q;

    a_bvalid_held: assert property (@(posedge clk) disable iff (reset)
        bvalid_q && !axil_req.bready |=> bvalid_q);

endmodule

`default_nettype wire

//--- reorder_buffer/rob_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module rob_bypass #(
    parameter int ROB_SIZE = 10
) (
    input  logic [ROB_SIZE-1:0]             ent_valid,
    input  logic [ROB_SIZE-1:0]             ent_done,
    input  logic [ROB_SIZE-1:0][4:0]        ent_rd,
    input  logic [ROB_SIZE-1:0][31:0]       ent_value,
    input  logic [rob_pkg::ROB_IDX_W-1:0]   head,
    input  logic [rob_pkg::ROB_IDX_W-1:0]   tail,
    input  logic [4:0]                      rs1,
    input  logic [4:0]                      rs2,
    output logic                            rs1_hit,
    output logic [31:0]                     rs1_value,
    output logic                            rs2_hit,
    output logic [31:0]                     rs2_value
);

    localparam int IDX_W = rob_pkg::ROB_IDX_W;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ROB_SIZE - 1);

    // Walk from just below the tail toward the head
    // First match found is the youngest
    always_comb begin
        logic [IDX_W-1:0] pos;
        logic             live;
        rs1_hit   = 1'b0;
        rs1_value = '0;
        rs2_hit   = 1'b0;
        rs2_value = '0;
        pos       = tail;
        live      = 1'b1;
        for (int k = 0; k < ROB_SIZE; k++) begin
            pos = (pos == '0) ? LAST_IDX : pos - 1'b1;
            if (live && ent_valid[pos] && ent_done[pos]) begin
                if (!rs1_hit && rs1 != 5'd0 && ent_rd[pos] == rs1) begin
                    rs1_hit   = 1'b1;
                    rs1_value = ent_value[pos];
                end
                if (!rs2_hit && rs2 != 5'd0 && ent_rd[pos] == rs2) begin
                    rs2_hit   = 1'b1;
                    rs2_value = ent_value[pos];
                end
            end
            // Oldest live entry reached
            if (pos == head) begin
                live = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- reorder_buffer/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_SIZE = 10
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   alloc_valid,
    input  rob_pkg::alloc_req_t                    alloc_req,
    output logic                                   alloc_ready,
    output logic [rob_pkg::ROB_IDX_W-1:0]          alloc_idx,
    input  rob_pkg::complete_t                     alu_cpl,
    input  rob_pkg::complete_t                     mem_cpl,
    input  rob_pkg::complete_t                     mul_cpl,
    input  logic                                   stall,
    input  logic                                   retire_hold,
    output rob_pkg::retire_t                       retire,
    output logic                                   rob_nuke,
    output logic [ROB_SIZE-1:0]                    ent_valid,
    output logic [ROB_SIZE-1:0]                    ent_done,
    output logic [ROB_SIZE-1:0][4:0]               ent_rd,
    output logic [ROB_SIZE-1:0][31:0]              ent_value,
    output logic [rob_pkg::ROB_IDX_W-1:0]          head,
    output logic [rob_pkg::ROB_IDX_W-1:0]          tail
);

    localparam int IDX_W = rob_pkg::ROB_IDX_W;
    localparam int CNT_W = IDX_W + 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(ROB_SIZE - 1);
    localparam int NUM_PORTS = 3;

    // Control state
    logic [ROB_SIZE-1:0] valid_q;
    logic [ROB_SIZE-1:0] done_q;
    logic [IDX_W-1:0]    head_q;
    logic [IDX_W-1:0]    tail_q;
    logic [CNT_W-1:0]    count_q;
    logic                ready_en_q;
    logic                nuke_q;

    // Per-entry payload
    logic [ROB_SIZE-1:0][4:0]  rd_q;
    logic [ROB_SIZE-1:0][31:0] value_q;
    logic [31:0]               pc_q        [ROB_SIZE];
    logic [31:0]               miss_addr_q [ROB_SIZE];
    rob_pkg::instr_type_e      itype_q     [ROB_SIZE];
    rob_pkg::exc_code_e        exc_q       [ROB_SIZE];

    rob_pkg::complete_t [NUM_PORTS-1:0] cpl;

    logic full;
    logic alloc_fire;
    logic retire_go;
    logic flush;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] i);
        return (i == LAST_IDX) ? '0 : i + 1'b1;
    endfunction

    assign cpl = {mul_cpl, mem_cpl, alu_cpl};

    assign full        = (count_q == CNT_W'(ROB_SIZE));
    assign alloc_ready = ready_en_q && !full;
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign alloc_idx   = tail_q;

    // Head leaves when finished and nobody holds retirement
    assign retire_go = valid_q[head_q] && done_q[head_q] && !stall && !retire_hold;
    assign flush     = retire_go && (exc_q[head_q] != rob_pkg::EXC_NONE);

    always_comb begin
        retire.valid     = retire_go;
        retire.idx       = head_q;
        retire.pc        = pc_q[head_q];
        retire.miss_addr = miss_addr_q[head_q];
        retire.value     = value_q[head_q];
        retire.rd        = rd_q[head_q];
        retire.itype     = itype_q[head_q];
        retire.exc       = exc_q[head_q];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= '0;
            done_q     <= '0;
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            ready_en_q <= 1'b0;
            nuke_q     <= 1'b0;
        end else begin
            ready_en_q <= 1'b1;
            nuke_q     <= flush;
            if (flush) begin
                // Exception at the head drops every entry
                valid_q <= '0;
                done_q  <= '0;
                head_q  <= '0;
                tail_q  <= '0;
                count_q <= '0;
            end else begin
                if (retire_go) begin
                    valid_q[head_q] <= 1'b0;
                    done_q[head_q]  <= 1'b0;
                    head_q          <= next_idx(head_q);
                end
                if (alloc_fire) begin
                    valid_q[tail_q] <= 1'b1;
                    done_q[tail_q]  <= 1'b0;
                    tail_q          <= next_idx(tail_q);
                end
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (cpl[p].valid) begin
                        done_q[cpl[p].idx] <= 1'b1;
                    end
                end
                count_q <= count_q + CNT_W'(alloc_fire) - CNT_W'(retire_go);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            pc_q[tail_q]        <= alloc_req.pc;
            miss_addr_q[tail_q] <= alloc_req.miss_addr;
            rd_q[tail_q]        <= alloc_req.rd;
            itype_q[tail_q]     <= alloc_req.itype;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (cpl[p].valid) begin
                value_q[cpl[p].idx] <= cpl[p].value;
                exc_q[cpl[p].idx]   <= cpl[p].exc;
            end
        end
    end

    assign rob_nuke  = nuke_q;
    assign ent_valid = valid_q;
    assign ent_done  = done_q;
    assign ent_rd    = rd_q;
    assign ent_value = value_q;
    assign head      = head_q;
    assign tail      = tail_q;

    // Execution units only finish instructions that are in flight
    a_cpl_live: assert property (@(posedge clk) disable iff (reset)
        (!alu_cpl.valid || valid_q[alu_cpl.idx]) &&
        (!mem_cpl.valid || valid_q[mem_cpl.idx]) &&
        (!mul_cpl.valid || valid_q[mul_cpl.idx]));

    a_cpl_no_collide: assert property (@(posedge clk) disable iff (reset)
        !(alu_cpl.valid && mem_cpl.valid && alu_cpl.idx == mem_cpl.idx) &&
        !(alu_cpl.valid && mul_cpl.valid && alu_cpl.idx == mul_cpl.idx) &&
        !(mem_cpl.valid && mul_cpl.valid && mem_cpl.idx == mul_cpl.idx));

    // Occupancy matches the number of live entries
    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count_q <= CNT_W'(ROB_SIZE) && count_q == CNT_W'($countones(valid_q)));

endmodule

`default_nettype wire

//--- common/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Entry index wide enough for the largest supported ROB (16)
    localparam int ROB_IDX_W = 4;

    typedef enum logic [2:0] {
        ITYPE_ALU   = 3'd0,
        ITYPE_MUL   = 3'd1,
        ITYPE_LOAD  = 3'd2,
        ITYPE_STORE = 3'd3,
        ITYPE_MOVRM = 3'd4,
        ITYPE_IRET  = 3'd5
    } instr_type_e;

    typedef enum logic [2:0] {
        EXC_NONE       = 3'd0,
        EXC_ILLEGAL    = 3'd1,
        EXC_INSTR_MISS = 3'd2,
        EXC_DATA_MISS  = 3'd3,
        EXC_PRIV       = 3'd4
    } exc_code_e;

    // Sent by decode with each allocation
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] miss_addr;
        logic [4:0]  rd;
        instr_type_e itype;
        logic [2:0]  padding;
    } alloc_req_t;

    // One result from an execution unit
    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] idx;
        logic [31:0]          value;
        exc_code_e            exc;
    } complete_t;

    // Instruction leaving the head of the ROB
    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] idx;
        logic [31:0]          pc;
        logic [31:0]          miss_addr;
        logic [31:0]          value;
        logic [4:0]           rd;
        instr_type_e          itype;
        exc_code_e            exc;
    } retire_t;

    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    localparam logic [1:0] AXIL_OKAY = 2'b00;

    // Privileged register map
    localparam logic [7:0] RM_LAST_OFS = 8'h1C;
    localparam logic [7:0] CTRL_OFS    = 8'h20;
    localparam logic [7:0] RETIRED_OFS = 8'h24;

endpackage

`default_nettype wire
